// ==== rtl/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit (
    input  logic                     clk_50MHz,
    input  logic                     reset_regs,
    input  y86Pkg::instrT            instr_i,
    input  logic [y86Pkg::WordW-1:0] valA_i,
    input  logic [y86Pkg::WordW-1:0] valB_i,
    input  logic                     aFromValC_i,
    input  logic                     bZero_i,
    input  logic                     loadCc_i,
    output logic [y86Pkg::WordW-1:0] valE_o,
    output logic                     condTrue_o
);

    localparam int Msb = y86Pkg::WordW - 1;

    logic [y86Pkg::WordW-1:0] aluA;
    logic [y86Pkg::WordW-1:0] aluB;
    y86Pkg::aluOpT            aluOp;
    y86Pkg::ccT               cc;
    y86Pkg::ccT               ccNext;

    assign aluA  = aFromValC_i ? instr_i.valC : valA_i;
    assign aluB  = bZero_i ? '0 : valB_i;
    assign aluOp = (instr_i.icode == y86Pkg::IOp) ? y86Pkg::aluOpT'(instr_i.ifun)
                                                  : y86Pkg::AluAdd;

    always_comb begin
        ccNext.of = 1'b0;
        case (aluOp)
            y86Pkg::AluSub: begin
                // B minus A
                valE_o    = aluB - aluA;
                ccNext.of = (aluB[Msb] != aluA[Msb]) && (valE_o[Msb] != aluB[Msb]);
            end
            y86Pkg::AluAnd: valE_o = aluB & aluA;
            y86Pkg::AluXor: valE_o = aluB ^ aluA;
            default: begin
                valE_o    = aluB + aluA;
                ccNext.of = (aluA[Msb] == aluB[Msb]) && (valE_o[Msb] != aluA[Msb]);
            end
        endcase
        ccNext.zf = (valE_o == '0);
        ccNext.sf = valE_o[Msb];
    end

    always_ff @(posedge clk_50MHz or posedge reset_regs) begin
        if (reset_regs) begin
            cc <= '0;
        end else if (loadCc_i) begin
            cc <= ccNext;
        end
    end

    // Condition from the stored flags
    always_comb begin
        case (instr_i.ifun)
            y86Pkg::CondAlways: condTrue_o = 1'b1;
            y86Pkg::CondLe:     condTrue_o = (cc.sf ^ cc.of) | cc.zf;
            y86Pkg::CondL:      condTrue_o = cc.sf ^ cc.of;
            y86Pkg::CondE:      condTrue_o = cc.zf;
            y86Pkg::CondNe:     condTrue_o = !cc.zf;
            y86Pkg::CondGe:     condTrue_o = !(cc.sf ^ cc.of);
            y86Pkg::CondG:      condTrue_o = !(cc.sf ^ cc.of) && !cc.zf;
            default:            condTrue_o = 1'b0;
        endcase
    end

    ccLoadOnlyForOp: assert property (@(posedge clk_50MHz) disable iff (reset_regs)
        loadCc_i |-> instr_i.icode == y86Pkg::IOp);

endmodule

// ==== rtl/byteBusIf.sv ====
`timescale 1ns/100ps

// One byte transfer, held until ack is seen at a clock edge
interface byteBusIf;

    logic                     req;
    logic                     write;
    logic [y86Pkg::WordW-1:0] addr;
    logic [7:0]               wdata;
    logic [7:0]               rdata;
    logic                     ack;

    modport requester (
        output req, write, addr, wdata,
        input  rdata, ack
    );

    modport server (
        input  req, write, addr, wdata,
        output rdata, ack
    );

endinterface

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/100ps

module fetchUnit (
    input  logic          clk_50MHz,
    input  logic          reset_regs,
    input  logic          fetchReq_i,
    input  logic          loadPc_i,
    input  logic          pcFromValC_i,
    byteBusIf.requester   bus,
    output y86Pkg::instrT instr_o,
    output logic          fetchDone_o
);

    logic [y86Pkg::WordW-1:0] pc;
    logic [2:0]               byteCnt;
    logic                     busy;
    logic [7:0]               byteBuf [6];
    logic [3:0]               curIcode;
    logic                     lastByte;

    // Length in bytes, one for anything undefined
    function automatic logic [2:0] instrLen(input logic [3:0] icode);
        case (icode)
            y86Pkg::IRrmov, y86Pkg::IOp:                    instrLen = 3'd2;
            y86Pkg::IIrmov, y86Pkg::IRmmov, y86Pkg::IMrmov: instrLen = 3'd6;
            y86Pkg::IJxx:                                   instrLen = 3'd5;
            default:                                        instrLen = 3'd1;
        endcase
    endfunction

    // Byte 0 decides the length while it is still on the bus
    assign curIcode = (byteCnt == 3'd0) ? bus.rdata[7:4] : byteBuf[0][7:4];
    assign lastByte = (byteCnt + 3'd1) == instrLen(curIcode);

    assign bus.req   = busy;
    assign bus.write = 1'b0;
    assign bus.wdata = '0;
    assign bus.addr  = pc + {{(y86Pkg::WordW-3){1'b0}}, byteCnt};

    always_ff @(posedge clk_50MHz or posedge reset_regs) begin
        if (reset_regs) begin
            busy        <= 1'b0;
            byteCnt     <= '0;
            fetchDone_o <= 1'b0;
        end else begin
            fetchDone_o <= 1'b0;
            if (busy) begin
                if (bus.ack) begin
                    if (lastByte) begin
                        busy        <= 1'b0;
                        fetchDone_o <= 1'b1;
                    end else begin
                        byteCnt <= byteCnt + 3'd1;
                    end
                end
            end else if (fetchReq_i && !fetchDone_o) begin
                // Request is held until done, so skip the done cycle
                busy    <= 1'b1;
                byteCnt <= '0;
            end
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (busy && bus.ack) begin
            byteBuf[byteCnt] <= bus.rdata;
        end
    end

    always_ff @(posedge clk_50MHz or posedge reset_regs) begin
        if (reset_regs) begin
            pc <= '0;
        end else if (loadPc_i) begin
            pc <= pcFromValC_i ? instr_o.valC : instr_o.valP;
        end
    end

    ////////////////////////////////////////
    // Field split
    ////////////////////////////////////////
    always_comb begin
        instr_o.icode = y86Pkg::opcodeT'(byteBuf[0][7:4]);
        instr_o.ifun  = byteBuf[0][3:0];
        instr_o.rA    = byteBuf[1][7:4];
        instr_o.rB    = byteBuf[1][3:0];
        // jXX has no register byte
        if (byteBuf[0][7:4] == y86Pkg::IJxx) begin
            instr_o.valC = {byteBuf[4], byteBuf[3], byteBuf[2], byteBuf[1]};
        end else begin
            instr_o.valC = {byteBuf[5], byteBuf[4], byteBuf[3], byteBuf[2]};
        end
        instr_o.valP = pc + {{(y86Pkg::WordW-3){1'b0}}, instrLen(byteBuf[0][7:4])};
    end

endmodule

// ==== rtl/memUnit.sv ====
`timescale 1ns/100ps

module memUnit (
    input  logic                     clk_50MHz,
    input  logic                     reset_regs,
    byteBusIf.server                 fetchBus,
    input  logic [y86Pkg::WordW-1:0] valE_i,
    input  logic [y86Pkg::WordW-1:0] valA_i,
    input  logic                     loadMar_i,
    input  logic                     loadMdr_i,
    input  logic                     dataReq_i,
    input  logic                     dataWrite_i,
    input  logic [7:0]               memRdata_i,
    input  logic                     memReady_i,
    output logic [y86Pkg::WordW-1:0] memAddr_o,
    output logic                     memRead_o,
    output logic                     memWrite_o,
    output logic [7:0]               memWdata_o,
    output logic [y86Pkg::WordW-1:0] valM_o,
    output logic                     dataDone_o
);

    logic [y86Pkg::WordW-1:0] mar;
    logic [y86Pkg::WordW-1:0] mdr;
    logic                     busy;
    logic                     isWrite;
    logic [1:0]               byteIdx;
    logic                     dataAck;

    assign dataAck = busy && memReady_i;

    ////////////////////////////////////////
    // Bus arbitration
    ////////////////////////////////////////
    // Fetch owns the bus whenever no data word is in progress
    assign memAddr_o  = busy ? mar + {{(y86Pkg::WordW-2){1'b0}}, byteIdx} : fetchBus.addr;
    assign memRead_o  = busy ? !isWrite : fetchBus.req && !fetchBus.write;
    assign memWrite_o = busy ? isWrite : fetchBus.req && fetchBus.write;
    assign memWdata_o = busy ? mdr[8*byteIdx +: 8] : fetchBus.wdata;

    assign fetchBus.rdata = memRdata_i;
    assign fetchBus.ack   = !busy && fetchBus.req && memReady_i;

    always_ff @(posedge clk_50MHz) begin
        if (loadMar_i) begin
            mar <= valE_i;
        end
        if (loadMdr_i) begin
            mdr <= valA_i;
        end
        // Little endian, byte 0 first
        if (dataAck && !isWrite) begin
            valM_o[8*byteIdx +: 8] <= memRdata_i;
        end
    end

    // Four-byte sequencer
    always_ff @(posedge clk_50MHz or posedge reset_regs) begin
        if (reset_regs) begin
            busy       <= 1'b0;
            isWrite    <= 1'b0;
            byteIdx    <= '0;
            dataDone_o <= 1'b0;
        end else begin
            dataDone_o <= 1'b0;
            if (busy) begin
                if (memReady_i) begin
                    byteIdx <= byteIdx + 2'd1;
                    if (byteIdx == 2'd3) begin
                        busy       <= 1'b0;
                        dataDone_o <= 1'b1;
                    end
                end
            end else if (dataReq_i && !dataDone_o) begin
                busy    <= 1'b1;
                isWrite <= dataWrite_i;
                byteIdx <= '0;
            end
        end
    end

    noReadWithWrite: assert property (@(posedge clk_50MHz) disable iff (reset_regs)
        !(memRead_o && memWrite_o));

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic                       clk_50MHz,
    input  logic                       reset_regs,
    input  logic [y86Pkg::RegIdxW-1:0] srcA_i,
    input  logic [y86Pkg::RegIdxW-1:0] srcB_i,
    input  logic [y86Pkg::RegIdxW-1:0] dst_i,
    input  logic                       write_i,
    input  logic [y86Pkg::WordW-1:0]   wdata_i,
    output logic [y86Pkg::WordW-1:0]   valA_o,
    output logic [y86Pkg::WordW-1:0]   valB_o
);

    logic [y86Pkg::WordW-1:0] regs [y86Pkg::NumRegs];

    always_ff @(posedge clk_50MHz or posedge reset_regs) begin
        if (reset_regs) begin
            for (int i = 0; i < y86Pkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_i && dst_i != y86Pkg::RegNone) begin
            regs[dst_i[2:0]] <= wdata_i;
        end
    end

    // No register reads as zero
    assign valA_o = (srcA_i == y86Pkg::RegNone) ? '0 : regs[srcA_i[2:0]];
    assign valB_o = (srcB_i == y86Pkg::RegNone) ? '0 : regs[srcB_i[2:0]];

endmodule

// ==== rtl/y86Control.sv ====
`timescale 1ns/100ps

module y86Control (
    input  logic              clk_50MHz,
    input  logic              reset_regs,
    input  y86Pkg::instrT     instr_i,
    input  logic              condTrue_i,
    input  logic              fetchDone_i,
    input  logic              dataDone_i,
    output logic              fetchReq_o,
    output logic              loadPc_o,
    output logic              pcFromValC_o,
    output logic              regWrite_o,
    output logic              regDstFromRa_o,
    output logic              regWdataFromMem_o,
    output logic              aluAFromValC_o,
    output logic              aluBZero_o,
    output logic              loadCc_o,
    output logic              loadMar_o,
    output logic              loadMdr_o,
    output logic              dataReq_o,
    output logic              dataWrite_o,
    output y86Pkg::cpuStatusT status_o,
    output logic              halted_o
);

    y86Pkg::ctrlStateT state;
    y86Pkg::ctrlStateT nextState;
    y86Pkg::opcodeT    icode;
    logic              validOp;
    logic              isMem;

    assign icode   = instr_i.icode;
    assign validOp = icode inside {y86Pkg::IHalt, y86Pkg::INop, y86Pkg::IRrmov,
                                   y86Pkg::IIrmov, y86Pkg::IRmmov, y86Pkg::IMrmov,
                                   y86Pkg::IOp, y86Pkg::IJxx};
    assign isMem   = (icode == y86Pkg::IRmmov) || (icode == y86Pkg::IMrmov);

    ////////////////////////////////////////
    // Microsequencer
    ////////////////////////////////////////
    always_comb begin
        case (state)
            y86Pkg::SFetch:     nextState = fetchDone_i ? y86Pkg::SDecode : y86Pkg::SFetch;
            y86Pkg::SDecode:    nextState = (validOp && icode != y86Pkg::IHalt) ?
                                            y86Pkg::SExecute : y86Pkg::SHalt;
            y86Pkg::SExecute:   nextState = isMem ? y86Pkg::SMemAddr : y86Pkg::SWriteBack;
            y86Pkg::SMemAddr:   nextState = y86Pkg::SMemWait;
            y86Pkg::SMemWait:   nextState = dataDone_i ? y86Pkg::SWriteBack : y86Pkg::SMemWait;
            y86Pkg::SWriteBack: nextState = y86Pkg::SPcUpdate;
            y86Pkg::SPcUpdate:  nextState = y86Pkg::SFetch;
            default:            nextState = y86Pkg::SHalt;
        endcase
    end

    always_ff @(posedge clk_50MHz or posedge reset_regs) begin
        if (reset_regs) begin
            state    <= y86Pkg::SFetch;
            status_o <= y86Pkg::StatAok;
        end else begin
            state <= nextState;
            // Status is settled once per instruction at decode
            if (state == y86Pkg::SDecode) begin
                if (!validOp) begin
                    status_o <= y86Pkg::StatIns;
                end else if (icode == y86Pkg::IHalt) begin
                    status_o <= y86Pkg::StatHlt;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Strobes and selects
    ////////////////////////////////////////
    assign fetchReq_o  = (state == y86Pkg::SFetch);
    assign loadCc_o    = (state == y86Pkg::SExecute) && (icode == y86Pkg::IOp);
    assign loadMar_o   = (state == y86Pkg::SMemAddr);
    assign loadMdr_o   = (state == y86Pkg::SMemAddr) && (icode == y86Pkg::IRmmov);
    assign dataReq_o   = (state == y86Pkg::SMemWait);
    assign dataWrite_o = (icode == y86Pkg::IRmmov);
    assign loadPc_o    = (state == y86Pkg::SPcUpdate);
    assign halted_o    = (state == y86Pkg::SHalt);

    // Taken jump only
    assign pcFromValC_o = (icode == y86Pkg::IJxx) && condTrue_i;

    // A is valC for irmovl and the displacement forms, B is zero for moves
    assign aluAFromValC_o    = icode inside {y86Pkg::IIrmov, y86Pkg::IRmmov, y86Pkg::IMrmov};
    assign aluBZero_o        = icode inside {y86Pkg::IRrmov, y86Pkg::IIrmov};
    assign regDstFromRa_o    = (icode == y86Pkg::IMrmov);
    assign regWdataFromMem_o = (icode == y86Pkg::IMrmov);

    always_comb begin
        regWrite_o = 1'b0;
        if (state == y86Pkg::SWriteBack) begin
            case (icode)
                // rrmovl is cmov with the always condition
                y86Pkg::IRrmov: regWrite_o = condTrue_i;
                y86Pkg::IIrmov,
                y86Pkg::IOp,
                y86Pkg::IMrmov: regWrite_o = 1'b1;
                default:        regWrite_o = 1'b0;
            endcase
        end
    end

    // Fetch and data transfers share the one byte bus
    busOwnerExclusive: assert property (@(posedge clk_50MHz) disable iff (reset_regs)
        !(dataReq_o && fetchReq_o));

endmodule

// ==== rtl/y86Core.sv ====
`timescale 1ns/100ps

module y86Core (
    input  logic                     clk_50MHz,
    input  logic                     reset_regs,
    output logic [y86Pkg::WordW-1:0] memAddr_o,
    output logic                     memRead_o,
    output logic                     memWrite_o,
    output logic [7:0]               memWdata_o,
    input  logic [7:0]               memRdata_i,
    input  logic                     memReady_i,
    output y86Pkg::cpuStatusT        status_o,
    output logic                     halted_o
);

    y86Pkg::instrT              instr;
    logic [y86Pkg::WordW-1:0]   valA;
    logic [y86Pkg::WordW-1:0]   valB;
    logic [y86Pkg::WordW-1:0]   valE;
    logic [y86Pkg::WordW-1:0]   valM;
    logic [y86Pkg::WordW-1:0]   regWdata;
    logic [y86Pkg::RegIdxW-1:0] regDst;
    logic fetchReq, fetchDone, loadPc, pcFromValC;
    logic regWrite, regDstFromRa, regWdataFromMem;
    logic aluAFromValC, aluBZero, loadCc, condTrue;
    logic loadMar, loadMdr, dataReq, dataWrite, dataDone;

    byteBusIf fetchBus ();

    assign regDst   = regDstFromRa ? instr.rA : instr.rB;
    assign regWdata = regWdataFromMem ? valM : valE;

    y86Control control (
        .clk_50MHz, .reset_regs, .instr_i(instr), .condTrue_i(condTrue),
        .fetchDone_i(fetchDone), .dataDone_i(dataDone), .fetchReq_o(fetchReq),
        .loadPc_o(loadPc), .pcFromValC_o(pcFromValC), .regWrite_o(regWrite),
        .regDstFromRa_o(regDstFromRa), .regWdataFromMem_o(regWdataFromMem),
        .aluAFromValC_o(aluAFromValC), .aluBZero_o(aluBZero), .loadCc_o(loadCc),
        .loadMar_o(loadMar), .loadMdr_o(loadMdr), .dataReq_o(dataReq),
        .dataWrite_o(dataWrite), .status_o, .halted_o
    );

    fetchUnit fetch (
        .clk_50MHz, .reset_regs, .fetchReq_i(fetchReq), .loadPc_i(loadPc),
        .pcFromValC_i(pcFromValC), .bus(fetchBus.requester), .instr_o(instr),
        .fetchDone_o(fetchDone)
    );

    regFile regs (
        .clk_50MHz, .reset_regs, .srcA_i(instr.rA), .srcB_i(instr.rB), .dst_i(regDst),
        .write_i(regWrite), .wdata_i(regWdata), .valA_o(valA), .valB_o(valB)
    );

    aluUnit alu (
        .clk_50MHz, .reset_regs, .instr_i(instr), .valA_i(valA), .valB_i(valB),
        .aFromValC_i(aluAFromValC), .bZero_i(aluBZero), .loadCc_i(loadCc),
        .valE_o(valE), .condTrue_o(condTrue)
    );

    memUnit mem (
        .clk_50MHz, .reset_regs, .fetchBus(fetchBus.server), .valE_i(valE),
        .valA_i(valA), .loadMar_i(loadMar), .loadMdr_i(loadMdr), .dataReq_i(dataReq),
        .dataWrite_i(dataWrite), .memRdata_i, .memReady_i, .memAddr_o, .memRead_o,
        .memWrite_o, .memWdata_o, .valM_o(valM), .dataDone_o(dataDone)
    );

endmodule

// ==== rtl/y86Pkg.sv ====
package y86Pkg;

    ////////////////////////////////////////
    // Widths and register file
    ////////////////////////////////////////
    localparam int WordW   = 32;
    localparam int RegIdxW = 4;
    localparam int NumRegs = 8;

    // Register index F reads as zero and is never written
    localparam logic [RegIdxW-1:0] RegNone = 4'hF;

    ////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        IHalt  = 4'h0,
        INop   = 4'h1,
        IRrmov = 4'h2,
        IIrmov = 4'h3,
        IRmmov = 4'h4,
        IMrmov = 4'h5,
        IOp    = 4'h6,
        IJxx   = 4'h7
    } opcodeT;

    typedef enum logic [3:0] {
        AluAdd = 4'h0,
        AluSub = 4'h1,
        AluAnd = 4'h2,
        AluXor = 4'h3
    } aluOpT;

    typedef enum logic [3:0] {
        CondAlways = 4'h0,
        CondLe     = 4'h1,
        CondL      = 4'h2,
        CondE      = 4'h3,
        CondNe     = 4'h4,
        CondGe     = 4'h5,
        CondG      = 4'h6
    } condT;

    typedef struct packed {
        logic zf;
        logic sf;
        logic of;
    } ccT;

    // Decoded fields of the instruction in flight
    typedef struct packed {
        opcodeT             icode;
        logic [3:0]         ifun;
        logic [RegIdxW-1:0] rA;
        logic [RegIdxW-1:0] rB;
        logic [WordW-1:0]   valC;
        logic [WordW-1:0]   valP;
    } instrT;

    typedef enum logic [1:0] {
        StatAok = 2'd0,
        StatHlt = 2'd1,
        StatIns = 2'd2
    } cpuStatusT;

    typedef enum logic [3:0] {
        SFetch,
        SDecode,
        SExecute,
        SMemAddr,
        SMemWait,
        SWriteBack,
        SPcUpdate,
        SHalt
    } ctrlStateT;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the Y86 core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module y86Tb -f sim.f
./obj_dir/Vy86Tb 2>&1 | tee sim.log

if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then
    echo "SIMULATION FAILED"
    exit 1
fi
echo "SIMULATION OK"

// ==== sim.f ====
rtl/y86Pkg.sv
rtl/byteBusIf.sv
rtl/y86Control.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/memUnit.sv
rtl/y86Core.sv
tb/y86Tb.sv

// ==== tb/y86Tb.sv ====
`timescale 1ns/100ps

module y86Tb;

    localparam logic [31:0] LfsrSeed    = 32'h6aa95769;
    localparam logic [31:0] LfsrTaps    = 32'h80200003;
    localparam int          HaltTimeout = 20000;
    localparam logic [31:0] Marker      = 32'hA5C3_0F71;
    localparam logic [31:0] JumpBase    = 32'h0000_0600;
    localparam logic [31:0] CmovBase    = 32'h0000_0680;

    localparam logic [3:0] RegEax = 4'h0;
    localparam logic [3:0] RegEcx = 4'h1;
    localparam logic [3:0] RegEdx = 4'h2;
    localparam logic [3:0] RegEbx = 4'h3;
    localparam logic [3:0] RegEsi = 4'h6;
    localparam logic [3:0] RegEdi = 4'h7;

    logic                     clk_50MHz;
    logic                     reset_regs = 1'b1;
    logic [y86Pkg::WordW-1:0] memAddr;
    logic                     memRead;
    logic                     memWrite;
    logic [7:0]               memWdata;
    logic [7:0]               memRdata = 8'h00;
    logic                     memReady = 1'b0;
    y86Pkg::cpuStatusT        status;
    logic                     halted;

    // Byte memory behind the core's bus
    logic [7:0]  memBytes [logic [31:0]];
    logic [31:0] progPc;
    logic [31:0] lfsr = LfsrSeed;
    logic        longDelay = 1'b0;
    int          waitLeft = 0;
    int          writeCount = 0;

    y86Core dut (
        .clk_50MHz, .reset_regs, .memAddr_o(memAddr), .memRead_o(memRead),
        .memWrite_o(memWrite), .memWdata_o(memWdata), .memRdata_i(memRdata),
        .memReady_i(memReady), .status_o(status), .halted_o(halted)
    );

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    ////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////
    function automatic logic takeBit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ LfsrTaps;
        end
        return b;
    endfunction

    // Ready delay in cycles, 0 to 3
    function automatic int drawDelay();
        int d;
        if (longDelay) begin
            return 3;
        end
        d = 0;
        d[0] = takeBit();
        d[1] = takeBit();
        return d;
    endfunction

    function automatic logic [7:0] readByte(input logic [31:0] addr);
        if (memBytes.exists(addr)) begin
            return memBytes[addr];
        end
        return 8'h00;
    endfunction

    function automatic logic [31:0] readWord(input logic [31:0] addr);
        return {readByte(addr + 3), readByte(addr + 2), readByte(addr + 1), readByte(addr)};
    endfunction

    // One transfer per ready pulse, the bus is held until then
    always @(negedge clk_50MHz) begin
        memReady <= 1'b0;
        if (memRead === 1'b1 || memWrite === 1'b1) begin
            if (waitLeft == 0) begin
                if (memWrite) begin
                    memBytes[memAddr] = memWdata;
                    writeCount++;
                end else begin
                    memRdata <= readByte(memAddr);
                end
                memReady <= 1'b1;
                waitLeft = drawDelay();
            end else begin
                waitLeft--;
            end
        end
    end

    ////////////////////////////////////////
    // Program assembly
    ////////////////////////////////////////
    task automatic putByte(input logic [7:0] b);
        memBytes[progPc] = b;
        progPc++;
    endtask

    task automatic putWord(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            putByte(w[8*i +: 8]);
        end
    endtask

    task automatic storeWordAt(input logic [31:0] addr, input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            memBytes[addr + i] = w[8*i +: 8];
        end
    endtask

    task automatic irmovl(input logic [31:0] v, input logic [3:0] rB);
        putByte({y86Pkg::IIrmov, 4'h0});
        putByte({y86Pkg::RegNone, rB});
        putWord(v);
    endtask

    task automatic rmmovl(input logic [3:0] rA, input logic [3:0] rB, input logic [31:0] d);
        putByte({y86Pkg::IRmmov, 4'h0});
        putByte({rA, rB});
        putWord(d);
    endtask

    // Loads rA from d(rB)
    task automatic mrmovl(input logic [3:0] rA, input logic [3:0] rB, input logic [31:0] d);
        putByte({y86Pkg::IMrmov, 4'h0});
        putByte({rA, rB});
        putWord(d);
    endtask

    task automatic opl(input y86Pkg::aluOpT fn, input logic [3:0] rA, input logic [3:0] rB);
        putByte({y86Pkg::IOp, fn});
        putByte({rA, rB});
    endtask

    task automatic cmovxx(input y86Pkg::condT fn, input logic [3:0] rA, input logic [3:0] rB);
        putByte({y86Pkg::IRrmov, fn});
        putByte({rA, rB});
    endtask

    task automatic jxx(input y86Pkg::condT fn, input logic [31:0] dest);
        putByte({y86Pkg::IJxx, fn});
        putWord(dest);
    endtask

    task automatic haltOp();
        putByte({y86Pkg::IHalt, 4'h0});
    endtask

    ////////////////////////////////////////
    // Checks and run control
    ////////////////////////////////////////
    task automatic abortRun();
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic reportProblem(input string what);
        $display("%s", what);
        abortRun();
    endtask

    task automatic checkWord(input logic [31:0] addr, input logic [y86Pkg::WordW-1:0] expected);
        logic [y86Pkg::WordW-1:0] got;
        got = readWord(addr);
        if (got !== expected) begin
            $display("[FAIL] mem[0x%h]: got 0x%h, expected 0x%h", addr, got, expected);
            abortRun();
        end
    endtask

    task automatic checkStatus(input string name, input y86Pkg::cpuStatusT got,
                               input y86Pkg::cpuStatusT expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            abortRun();
        end
    endtask

    // Condition rule on flags of B minus A
    function automatic logic condHolds(input y86Pkg::condT c, input logic zf,
                                       input logic sf, input logic of);
        logic less;
        less = (sf != of);
        case (c)
            y86Pkg::CondAlways: return 1'b1;
            y86Pkg::CondLe:     return less || zf;
            y86Pkg::CondL:      return less;
            y86Pkg::CondE:      return zf;
            y86Pkg::CondNe:     return !zf;
            y86Pkg::CondGe:     return !less;
            y86Pkg::CondG:      return !less && !zf;
            default:            return 1'b0;
        endcase
    endfunction

    task automatic startProgram();
        memBytes.delete();
        progPc = 32'h0;
    endtask

    task automatic pulseReset();
        @(negedge clk_50MHz);
        reset_regs = 1'b1;
        repeat (16) @(negedge clk_50MHz);
        reset_regs = 1'b0;
        checkStatus("status_o after reset", status, y86Pkg::StatAok);
        if (halted !== 1'b0) begin
            reportProblem("halted_o is high right after reset");
        end
    endtask

    task automatic waitHalted();
        for (int i = 0; i < HaltTimeout && halted !== 1'b1; i++) begin
            @(negedge clk_50MHz);
        end
        if (halted !== 1'b1) begin
            reportProblem("timeout while waiting for halted_o to rise");
        end
    endtask

    task automatic runProgram();
        pulseReset();
        waitHalted();
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic testStoreConst();
        startProgram();
        irmovl(32'h1234_5678, RegEax);
        irmovl(32'hCAFE_F00D, RegEcx);
        irmovl(32'h0000_0200, RegEbx);
        rmmovl(RegEax, RegEbx, 32'h0);
        rmmovl(RegEcx, y86Pkg::RegNone, 32'h208);
        haltOp();
        runProgram();
        checkStatus("status_o", status, y86Pkg::StatHlt);
        checkWord(32'h200, 32'h1234_5678);
        checkWord(32'h208, 32'hCAFE_F00D);
    endtask

    task automatic testOpl(input logic slowMem, input logic [31:0] opA, input logic [31:0] opB);
        longDelay = slowMem;
        startProgram();
        irmovl(opA, RegEax);
        irmovl(opB, RegEbx);
        cmovxx(y86Pkg::CondAlways, RegEbx, RegEcx);
        opl(y86Pkg::AluAdd, RegEax, RegEcx);
        rmmovl(RegEcx, y86Pkg::RegNone, 32'h300);
        cmovxx(y86Pkg::CondAlways, RegEbx, RegEdx);
        opl(y86Pkg::AluSub, RegEax, RegEdx);
        rmmovl(RegEdx, y86Pkg::RegNone, 32'h304);
        cmovxx(y86Pkg::CondAlways, RegEbx, RegEsi);
        opl(y86Pkg::AluAnd, RegEax, RegEsi);
        rmmovl(RegEsi, y86Pkg::RegNone, 32'h308);
        cmovxx(y86Pkg::CondAlways, RegEbx, RegEdi);
        opl(y86Pkg::AluXor, RegEax, RegEdi);
        rmmovl(RegEdi, y86Pkg::RegNone, 32'h30C);
        haltOp();
        runProgram();
        longDelay = 1'b0;
        checkStatus("status_o", status, y86Pkg::StatHlt);
        checkWord(32'h300, opB + opA);
        checkWord(32'h304, opB - opA);
        checkWord(32'h308, opB & opA);
        checkWord(32'h30C, opB ^ opA);
    endtask

    task automatic testMrmovl();
        startProgram();
        storeWordAt(32'h400, 32'h0BAD_F00D);
        storeWordAt(32'h404, 32'h1234_4321);
        irmovl(32'h400, RegEbx);
        mrmovl(RegEax, RegEbx, 32'h0);
        mrmovl(RegEcx, RegEbx, 32'h4);
        opl(y86Pkg::AluAdd, RegEax, RegEcx);
        rmmovl(RegEcx, y86Pkg::RegNone, 32'h408);
        haltOp();
        runProgram();
        checkStatus("status_o", status, y86Pkg::StatHlt);
        checkWord(32'h408, 32'h0BAD_F00D + 32'h1234_4321);
    endtask

    task automatic condPair(input logic [31:0] a, input logic [31:0] b);
        logic [31:0]  diff;
        longint       exactDiff;
        logic         zf;
        logic         sf;
        logic         of;
        logic         taken;
        y86Pkg::condT cond;
        diff = b - a;
        zf = (diff == 32'h0);
        sf = diff[31];
        // Overflow when the exact signed result leaves the 32-bit range
        exactDiff = longint'($signed(b)) - longint'($signed(a));
        of = (exactDiff > 64'sd2147483647) || (exactDiff < -64'sd2147483648);
        startProgram();
        irmovl(a, RegEax);
        irmovl(b, RegEbx);
        irmovl(Marker, RegEdi);
        opl(y86Pkg::AluSub, RegEax, RegEbx);
        for (int k = 0; k < 7; k++) begin
            cond = y86Pkg::condT'(k);
            // Jump over the store when taken
            jxx(cond, progPc + 32'd11);
            rmmovl(RegEdi, y86Pkg::RegNone, JumpBase + 4 * k);
            irmovl(32'h0, RegEsi);
            cmovxx(cond, RegEdi, RegEsi);
            rmmovl(RegEsi, y86Pkg::RegNone, CmovBase + 4 * k);
        end
        haltOp();
        runProgram();
        checkStatus("status_o", status, y86Pkg::StatHlt);
        for (int k = 0; k < 7; k++) begin
            taken = condHolds(y86Pkg::condT'(k), zf, sf, of);
            checkWord(JumpBase + 4 * k, taken ? 32'h0 : Marker);
            checkWord(CmovBase + 4 * k, taken ? Marker : 32'h0);
        end
    endtask

    task automatic testConditions();
        condPair(32'd5, 32'd5);
        condPair(32'd3, 32'd9);
        condPair(32'd9, 32'd3);
        // Signed overflow on the compare
        condPair(32'd1, 32'h8000_0000);
    endtask

    task automatic testInvalid();
        int writesBefore;
        startProgram();
        irmovl(32'h11, RegEax);
        rmmovl(RegEax, y86Pkg::RegNone, 32'h100);
        putByte(8'hE0);
        rmmovl(RegEax, y86Pkg::RegNone, 32'h104);
        haltOp();
        writesBefore = writeCount;
        runProgram();
        checkStatus("status_o", status, y86Pkg::StatIns);
        checkWord(32'h100, 32'h11);
        if (writeCount - writesBefore != 4) begin
            reportProblem("a memory write happened after the invalid instruction");
        end
        repeat (10) @(negedge clk_50MHz);
        if (halted !== 1'b1) begin
            reportProblem("halted_o fell without a reset");
        end
    endtask

    initial begin
        testStoreConst();
        testOpl(1'b0, 32'h1357_9BDF, 32'h8642_0ECA);
        testMrmovl();
        testConditions();
        testInvalid();
        // Same arithmetic with the slowest memory
        testOpl(1'b1, 32'h1357_9BDF, 32'h8642_0ECA);
        $display("all tests passed");
        $finish;
    end

endmodule
